//--- umi_pkg.sv
//##########################################################################
// UMI shared definitions
// opcode constants, atomic operation codes and the opcode byte union
// used by the command decoder, the ALU and the testbench
//##########################################################################
package umi_pkg;

   // transaction opcodes, full byte
   localparam logic [7:0] OP_INVALID        = 8'h00; // never a legal request
   localparam logic [7:0] OP_WRITE_NORMAL   = 8'h01;
   localparam logic [7:0] OP_WRITE_RESPONSE = 8'h02; // what the endpoint sends back
   localparam logic [7:0] OP_WRITE_SIGNAL   = 8'h03; // write with eot signal
   localparam logic [7:0] OP_WRITE_STREAM   = 8'h04;
   localparam logic [7:0] OP_WRITE_ACK      = 8'h05; // write, expects a response
   localparam logic [7:0] OP_READ           = 8'h08; // bit 3 marks read class

   // low nibble shared by every atomic
   localparam logic [3:0] OP_ATOMIC_BASE = 4'h9;

   // atomic operation, opcode bits 6:4, value 7 reserved
   typedef enum logic [2:0] {
      ATOMIC_SWAP = 3'd0,
      ATOMIC_ADD  = 3'd1,
      ATOMIC_AND  = 3'd2,
      ATOMIC_OR   = 3'd3,
      ATOMIC_XOR  = 3'd4,
      ATOMIC_MAX  = 3'd5,
      ATOMIC_MIN  = 3'd6
   } atomic_op_t;

   // one opcode byte, two readings
   typedef union packed {
      struct packed {
         logic [4:0] upper; // zero for plain writes
         logic [2:0] kind;  // write kind, 6 and 7 reserved
      } wr;
      struct packed {
         logic       spare;
         logic [2:0] op;    // atomic_op_t code
         logic [3:0] cls;   // class nibble, 9 for atomics
      } at;
   } umi_opcode_t;

endpackage

//--- umi_decode.sv
//##########################################################################
// UMI command decoder
// splits a 32-bit command into opcode, size and user fields and flags
// the transaction class, the write kind and the atomic operation
//##########################################################################
module umi_decode (
   input  logic [31:0]              cmd,                 // packet command
   output logic                     cmd_invalid,         // opcode zero
   output logic                     cmd_write,           // write class
   output logic                     cmd_read,            // read class, atomics included
   output logic                     cmd_atomic,          // read-modify-write
   output logic                     cmd_write_normal,
   output logic                     cmd_write_signal,    // write with eot signal
   output logic                     cmd_write_ack,       // write with acknowledge
   output logic                     cmd_write_stream,
   output logic                     cmd_write_response,
   output logic                     cmd_write_reserved,  // unknown write kind
   output umi_pkg::atomic_op_t      cmd_atomic_op,
   output logic                     cmd_atomic_reserved, // op code 7
   output umi_pkg::umi_opcode_t     cmd_opcode,          // raw opcode byte
   output logic [3:0]               cmd_size,            // burst length, carried only
   output logic [19:0]              cmd_user             // user field
);

   logic [2:0] wr_kind; // write view of the opcode
   logic [2:0] at_op;   // atomic view of the opcode

   // command fields
   assign cmd_opcode = cmd[7:0];
   assign cmd_size   = cmd[11:8];
   assign cmd_user   = cmd[31:12];

   assign wr_kind = cmd_opcode.wr.kind;
   assign at_op   = cmd_opcode.at.op;

   // class flags
   assign cmd_invalid = (cmd_opcode == umi_pkg::OP_INVALID);
   assign cmd_read    =  cmd_opcode[3] & ~cmd_invalid;
   assign cmd_write   = ~cmd_opcode[3] & ~cmd_invalid;
   assign cmd_atomic  = (cmd_opcode.at.cls == umi_pkg::OP_ATOMIC_BASE);

   // write kinds, only meaningful in the write class
   assign cmd_write_normal   = cmd_write & (wr_kind == umi_pkg::OP_WRITE_NORMAL[2:0]);
   assign cmd_write_response = cmd_write & (wr_kind == umi_pkg::OP_WRITE_RESPONSE[2:0]);
   assign cmd_write_signal   = cmd_write & (wr_kind == umi_pkg::OP_WRITE_SIGNAL[2:0]);
   assign cmd_write_stream   = cmd_write & (wr_kind == umi_pkg::OP_WRITE_STREAM[2:0]);
   assign cmd_write_ack      = cmd_write & (wr_kind == umi_pkg::OP_WRITE_ACK[2:0]);

   // kinds 6, 7 and kind 0 with upper bits set
   assign cmd_write_reserved = cmd_write & ((wr_kind == 3'd0) | (wr_kind[2:1] == 2'b11));

   // atomic op straight from bits 6:4
   assign cmd_atomic_op       = umi_pkg::atomic_op_t'(at_op);
   assign cmd_atomic_reserved = cmd_atomic & (at_op == 3'b111);

   // a write lands in exactly one kind bucket, anything else in none
   always_comb begin
      assert final (cmd_write ?
                    $onehot({cmd_write_normal, cmd_write_response, cmd_write_signal,
                             cmd_write_stream, cmd_write_ack, cmd_write_reserved}) :
                    ({cmd_write_normal, cmd_write_response, cmd_write_signal,
                      cmd_write_stream, cmd_write_ack, cmd_write_reserved} == 6'b0))
         else $error("umi_decode: write kind flags not one-hot for opcode %h",
                     cmd_opcode);
   end

endmodule

//--- umi_atomic_alu.sv
//##########################################################################
// UMI atomic ALU
// combinational read-modify-write result for swap, add, logic ops
// and signed min and max
//##########################################################################
module umi_atomic_alu #(
   parameter int DW = 32
) (
   input  umi_pkg::atomic_op_t op,       // from the decoder
   input  logic [DW-1:0]       old_data, // word currently in memory
   input  logic [DW-1:0]       operand,  // request data
   output logic [DW-1:0]       new_data  // word to store back
);

   logic op_gt_old; // signed compare, shared by min and max

   assign op_gt_old = ($signed(operand) > $signed(old_data));

   always_comb begin
      case (op)
         umi_pkg::ATOMIC_SWAP: begin
            new_data = operand; // plain exchange
         end
         umi_pkg::ATOMIC_ADD: begin
            new_data = old_data + operand; // wraps at DW bits
         end
         umi_pkg::ATOMIC_AND: begin
            new_data = old_data & operand;
         end
         umi_pkg::ATOMIC_OR: begin
            new_data = old_data | operand;
         end
         umi_pkg::ATOMIC_XOR: begin
            new_data = old_data ^ operand;
         end
         umi_pkg::ATOMIC_MAX: begin
            new_data = op_gt_old ? operand : old_data;
         end
         umi_pkg::ATOMIC_MIN: begin
            new_data = op_gt_old ? old_data : operand;
         end
         default: begin
            // reserved op 7, endpoint never stores this
            new_data = old_data;
         end
      endcase
   end

endmodule

//--- umi_mem_array.sv
//##########################################################################
// UMI word memory
// one registered read port and one write port, read returns the
// old word when both ports hit the same entry on one edge
//##########################################################################
module umi_mem_array #(
   parameter int DW    = 32,
   parameter int DEPTH = 256
) (
   input  logic                     clk,
   input  logic [$clog2(DEPTH)-1:0] rd_addr, // word index
   output logic [DW-1:0]            rd_data, // one cycle after rd_addr
   input  logic                     wr_en,
   input  logic [$clog2(DEPTH)-1:0] wr_addr, // word index
   input  logic [DW-1:0]            wr_data
);

   logic [DW-1:0] mem [DEPTH]; // contents undefined after power-up

   // write port
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // read first
   always_ff @(posedge clk) begin
      rd_data <= mem[rd_addr];
   end

   // non power of two depths leave holes in the index space
   a_wr_in_range: assert property (@(posedge clk) wr_en |-> (wr_addr < DEPTH))
      else $error("umi_mem_array: write index %0d outside depth %0d", wr_addr, DEPTH);

endmodule

//--- umi_mem_endpoint.sv
//##########################################################################
// UMI memory endpoint
// two-stage request pipeline where stage 1 decodes and starts the read
// and stage 2 forwards, runs the atomic, writes back and answers
// responses and error strobes come out two cycles after the request
//##########################################################################
module umi_mem_endpoint #(
   parameter int AW    = 32,
   parameter int DW    = 32,
   parameter int DEPTH = 256
) (
   input  logic          clk,
   input  logic          rst_n,
   input  logic          in_valid,    // request strobe
   input  logic [31:0]   in_cmd,
   input  logic [AW-1:0] in_dstaddr,  // memory address
   input  logic [AW-1:0] in_srcaddr,  // where the response goes
   input  logic [DW-1:0] in_data,
   output logic          out_valid,   // response strobe
   output logic [31:0]   out_cmd,
   output logic [AW-1:0] out_dstaddr,
   output logic [AW-1:0] out_srcaddr,
   output logic [DW-1:0] out_data,
   output logic          out_error    // bad request strobe
);

   localparam int IW = $clog2(DEPTH); // word index width

   // decoder outputs
   logic                dec_invalid;
   logic                dec_read;
   logic                dec_atomic;
   logic                dec_wr_normal;
   logic                dec_wr_signal;
   logic                dec_wr_ack;
   logic                dec_wr_stream;
   logic                dec_wr_reserved;
   umi_pkg::atomic_op_t dec_atomic_op;
   logic                dec_atomic_reserved;
   logic [3:0]          dec_size;
   logic [19:0]         dec_user;

   // request classes on the input cycle
   logic req_err;
   logic req_store; // write data as is
   logic req_rmw;   // legal atomic
   logic req_resp;  // needs an answer

   // stage 1
   logic                s1_err;   // control regs with reset
   logic                s1_store;
   logic                s1_rmw;
   logic                s1_resp;
   logic                s1_ack;   // payload from here on
   umi_pkg::atomic_op_t s1_op;
   logic [3:0]          s1_size;
   logic [19:0]         s1_user;
   logic [AW-1:0]       s1_dstaddr;
   logic [AW-1:0]       s1_srcaddr;
   logic [DW-1:0]       s1_data;
   logic [IW-1:0]       s1_idx;

   // stage 2
   logic [DW-1:0] rd_data;
   logic [DW-1:0] old_word;
   logic [DW-1:0] alu_data;
   logic          wr_en;
   logic [DW-1:0] wr_data;
   logic          wb_en;   // last edge's write kept for forwarding
   logic [IW-1:0] wb_idx;
   logic [DW-1:0] wb_data;

   umi_decode i_decode (
      .cmd                 (in_cmd),
      .cmd_invalid         (dec_invalid),
      .cmd_write           (),            // kinds carry the class already
      .cmd_read            (dec_read),
      .cmd_atomic          (dec_atomic),
      .cmd_write_normal    (dec_wr_normal),
      .cmd_write_signal    (dec_wr_signal),
      .cmd_write_ack       (dec_wr_ack),
      .cmd_write_stream    (dec_wr_stream),
      .cmd_write_response  (),            // incoming responses are dropped
      .cmd_write_reserved  (dec_wr_reserved),
      .cmd_atomic_op       (dec_atomic_op),
      .cmd_atomic_reserved (dec_atomic_reserved),
      .cmd_opcode          (),
      .cmd_size            (dec_size),
      .cmd_user            (dec_user)
   );

   assign req_err   = in_valid & (dec_invalid | dec_wr_reserved | dec_atomic_reserved);
   assign req_store = in_valid & (dec_wr_normal | dec_wr_signal | dec_wr_stream | dec_wr_ack);
   assign req_rmw   = in_valid & dec_atomic & ~dec_atomic_reserved;
   // plain reads, atomics and acked writes answer
   assign req_resp  = (in_valid & dec_read & ~dec_atomic) | req_rmw | (in_valid & dec_wr_ack);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         s1_err   <= 1'b0;
         s1_store <= 1'b0;
         s1_rmw   <= 1'b0;
         s1_resp  <= 1'b0;
      end else begin
         s1_err   <= req_err;
         s1_store <= req_store;
         s1_rmw   <= req_rmw;
         s1_resp  <= req_resp;
      end
   end

   always_ff @(posedge clk) begin
      s1_ack     <= dec_wr_ack;
      s1_op      <= dec_atomic_op;
      s1_size    <= dec_size;
      s1_user    <= dec_user;
      s1_dstaddr <= in_dstaddr;
      s1_srcaddr <= in_srcaddr;
      s1_data    <= in_data;
   end

   assign s1_idx = s1_dstaddr[IW+1:2]; // word select

   umi_mem_array #(
      .DW    (DW),
      .DEPTH (DEPTH)
   ) i_mem (
      .clk     (clk),
      .rd_addr (in_dstaddr[IW+1:2]), // read starts on the request cycle
      .rd_data (rd_data),
      .wr_en   (wr_en),
      .wr_addr (s1_idx),
      .wr_data (wr_data)
   );

   // memory read missed the write that landed on the same edge
   assign old_word = (wb_en && (wb_idx == s1_idx)) ? wb_data : rd_data;

   umi_atomic_alu #(
      .DW (DW)
   ) i_alu (
      .op       (s1_op),
      .old_data (old_word),
      .operand  (s1_data),
      .new_data (alu_data)
   );

   assign wr_en   = s1_store | s1_rmw;
   assign wr_data = s1_rmw ? alu_data : s1_data;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb_en     <= 1'b0;
         out_valid <= 1'b0;
         out_error <= 1'b0;
      end else begin
         wb_en     <= wr_en;
         out_valid <= s1_resp;
         out_error <= s1_err;
      end
   end

   always_ff @(posedge clk) begin
      wb_idx  <= s1_idx;
      wb_data <= wr_data;
      if (s1_resp) begin
         out_cmd     <= {s1_user, s1_size, umi_pkg::OP_WRITE_RESPONSE};
         out_dstaddr <= s1_srcaddr; // back to the requester
         out_srcaddr <= s1_dstaddr;
         out_data    <= s1_ack ? '0 : old_word; // old word for reads and atomics
      end
   end

   a_resp_err_excl: assert property (@(posedge clk) disable iff (!rst_n)
                                     !(out_valid && out_error))
      else $error("umi_mem_endpoint: response and error strobe together");

   a_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !out_valid && !out_error)
      else $error("umi_mem_endpoint: strobe seen during reset");

endmodule

//--- umi_endpoint_top.sv
//##########################################################################
// UMI endpoint top level
// fixes address width, data width and memory depth and hooks the
// request and response ports to the memory endpoint
//##########################################################################
module umi_endpoint_top #(
   parameter int AW    = 32,  // address width
   parameter int DW    = 32,  // one data word
   parameter int DEPTH = 256  // words of memory
) (
   input  logic          clk,
   input  logic          rst_n,
   // request side
   input  logic          in_valid,
   input  logic [31:0]   in_cmd,
   input  logic [AW-1:0] in_dstaddr,
   input  logic [AW-1:0] in_srcaddr,
   input  logic [DW-1:0] in_data,
   // response side
   output logic          out_valid,
   output logic [31:0]   out_cmd,
   output logic [AW-1:0] out_dstaddr,
   output logic [AW-1:0] out_srcaddr,
   output logic [DW-1:0] out_data,
   output logic          out_error
);

   umi_mem_endpoint #(
      .AW    (AW),
      .DW    (DW),
      .DEPTH (DEPTH)
   ) i_endpoint (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_cmd      (in_cmd),
      .in_dstaddr  (in_dstaddr),
      .in_srcaddr  (in_srcaddr),
      .in_data     (in_data),
      .out_valid   (out_valid),
      .out_cmd     (out_cmd),
      .out_dstaddr (out_dstaddr),
      .out_srcaddr (out_srcaddr),
      .out_data    (out_data),
      .out_error   (out_error)
   );

endmodule

//--- tb_umi_endpoint.sv
//##########################################################################
// UMI endpoint testbench
// drives strobed requests into the endpoint top level, keeps its own
// reference memory and checks every response and error strobe with
// concurrent assertions against a queue of expected output cycles
//##########################################################################
module tb_umi_endpoint;

   localparam int AW         = 32;
   localparam int DW         = 32;
   localparam int DEPTH      = 256;
   localparam int WINDOW     = 8;   // small window of words so addresses collide
   localparam int DIR_REQS   = 120; // upper bound on directed cycles
   localparam int RAND_REQS  = 160; // random cycles of idle or request
   localparam int MAX_CYCLES = 5 + DIR_REQS + RAND_REQS + 40; // reset, tests, margin

   // one expected output cycle
   typedef struct packed {
      logic          valid;
      logic          error;
      logic [31:0]   cmd;
      logic [AW-1:0] dst;
      logic [AW-1:0] src;
      logic [DW-1:0] data;
   } exp_t;

   logic          clk;
   logic          rst_n;
   logic          in_valid;
   logic [31:0]   in_cmd;
   logic [AW-1:0] in_dstaddr;
   logic [AW-1:0] in_srcaddr;
   logic [DW-1:0] in_data;
   logic          out_valid;
   logic [31:0]   out_cmd;
   logic [AW-1:0] out_dstaddr;
   logic [AW-1:0] out_srcaddr;
   logic [DW-1:0] out_data;
   logic          out_error;

   exp_t          exp_q[$];         // one entry per clock cycle
   string         name_q[$];        // test name per entry
   exp_t          exp_cur;          // entry checked at the next rising edge
   string         cur_name;
   logic [DW-1:0] ref_mem [WINDOW]; // reference copy of the touched words
   int            seed;
   int            cycle_count = 0;
   int            i;
   int            pick;
   logic [DW-1:0] rnd_old;
   logic [DW-1:0] rnd_opnd;
   logic [7:0]    rnd_opcode;

   umi_endpoint_top #(
      .AW    (AW),
      .DW    (DW),
      .DEPTH (DEPTH)
   ) i_dut (
      .clk         (clk),
      .rst_n       (rst_n),
      .in_valid    (in_valid),
      .in_cmd      (in_cmd),
      .in_dstaddr  (in_dstaddr),
      .in_srcaddr  (in_srcaddr),
      .in_data     (in_data),
      .out_valid   (out_valid),
      .out_cmd     (out_cmd),
      .out_dstaddr (out_dstaddr),
      .out_srcaddr (out_srcaddr),
      .out_data    (out_data),
      .out_error   (out_error)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // hung run guard
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: no end of test after %0d cycles", MAX_CYCLES);
         $display("tests failed");
         $fatal(1, "cycle limit reached");
      end
   end

   // head of the queue moves to exp_cur between rising edges
   always @(negedge clk) begin
      if (exp_q.size() > 0) begin
         exp_cur  = exp_q.pop_front();
         cur_name = name_q.pop_front();
      end else begin
         exp_cur  = '0; // outputs quiet when nothing is queued
         cur_name = "quiet";
      end
   end

   task automatic report_mismatch(input string what, input logic [31:0] expected,
                                  input logic [31:0] actual);
      $display("[ERROR] %s: %s expected %h actual %h", cur_name, what, expected, actual);
      $display("tests failed");
      $fatal(1, "stopped at first mismatch");
   endtask

   a_valid_match: assert property (@(posedge clk) disable iff (!rst_n)
                                   out_valid === exp_cur.valid)
      else report_mismatch("out_valid", 32'(exp_cur.valid), 32'($sampled(out_valid)));
   a_error_match: assert property (@(posedge clk) disable iff (!rst_n)
                                   out_error === exp_cur.error)
      else report_mismatch("out_error", 32'(exp_cur.error), 32'($sampled(out_error)));
   a_cmd_match: assert property (@(posedge clk) disable iff (!rst_n)
                                 exp_cur.valid |-> out_cmd === exp_cur.cmd)
      else report_mismatch("out_cmd", exp_cur.cmd, $sampled(out_cmd));
   a_dst_match: assert property (@(posedge clk) disable iff (!rst_n)
                                 exp_cur.valid |-> out_dstaddr === exp_cur.dst)
      else report_mismatch("out_dstaddr", exp_cur.dst, $sampled(out_dstaddr));
   a_src_match: assert property (@(posedge clk) disable iff (!rst_n)
                                 exp_cur.valid |-> out_srcaddr === exp_cur.src)
      else report_mismatch("out_srcaddr", exp_cur.src, $sampled(out_srcaddr));
   a_data_match: assert property (@(posedge clk) disable iff (!rst_n)
                                  exp_cur.valid |-> out_data === exp_cur.data)
      else report_mismatch("out_data", exp_cur.data, $sampled(out_data));

   // stored word after a read-modify-write
   function automatic logic [DW-1:0] atomic_result(input logic [2:0] op,
                                                  input logic [DW-1:0] old,
                                                  input logic [DW-1:0] operand);
      case (op)
         umi_pkg::ATOMIC_SWAP: return operand;
         umi_pkg::ATOMIC_ADD:  return old + operand;
         umi_pkg::ATOMIC_AND:  return old & operand;
         umi_pkg::ATOMIC_OR:   return old | operand;
         umi_pkg::ATOMIC_XOR:  return old ^ operand;
         umi_pkg::ATOMIC_MAX:  return ($signed(operand) > $signed(old)) ? operand : old;
         umi_pkg::ATOMIC_MIN:  return ($signed(operand) < $signed(old)) ? operand : old;
         default:              return old;
      endcase
   endfunction

   function automatic logic [7:0] atomic_opcode(input logic [2:0] op);
      umi_pkg::umi_opcode_t opc;
      opc.at.spare = 1'b0;
      opc.at.op    = op;
      opc.at.cls   = umi_pkg::OP_ATOMIC_BASE;
      return opc;
   endfunction

   // one request cycle with reference memory and expected output updated at issue
   task automatic send_request(input string name, input logic [7:0] opcode,
                               input int idx, input logic [DW-1:0] data);
      umi_pkg::umi_opcode_t opc;
      logic [3:0]    size;
      logic [19:0]   user;
      logic [AW-1:0] src;
      logic [AW-1:0] dst;
      logic [DW-1:0] old;
      exp_t          e;
      opc   = opcode;
      size  = 4'($random(seed));
      user  = 20'($random(seed));
      src   = AW'($random(seed));
      dst   = AW'(idx) << 2; // word index to byte address
      old   = ref_mem[idx];
      e     = '0;
      e.cmd = {user, size, umi_pkg::OP_WRITE_RESPONSE};
      e.dst = src;           // response goes back to the requester
      e.src = dst;
      if (opcode == umi_pkg::OP_INVALID) begin
         e.error = 1'b1;
      end else if (!opc[3]) begin
         case (opc.wr.kind)
            umi_pkg::OP_WRITE_NORMAL[2:0], umi_pkg::OP_WRITE_SIGNAL[2:0],
            umi_pkg::OP_WRITE_STREAM[2:0]: begin
               ref_mem[idx] = data; // silent store
            end
            umi_pkg::OP_WRITE_ACK[2:0]: begin
               ref_mem[idx] = data;
               e.valid      = 1'b1; // data stays zero
            end
            umi_pkg::OP_WRITE_RESPONSE[2:0]: begin
               e.valid = 1'b0; // dropped
            end
            default: begin
               e.error = 1'b1; // reserved kinds
            end
         endcase
      end else if (opc.at.cls == umi_pkg::OP_ATOMIC_BASE) begin
         if (opc.at.op == 3'd7) begin
            e.error = 1'b1;
         end else begin
            e.valid      = 1'b1;
            e.data       = old;
            ref_mem[idx] = atomic_result(opc.at.op, old, data);
         end
      end else begin
         e.valid = 1'b1; // plain read
         e.data  = old;
      end
      @(posedge clk);
      in_valid   <= 1'b1;
      in_cmd     <= {user, size, opcode};
      in_dstaddr <= dst;
      in_srcaddr <= src;
      in_data    <= data;
      exp_q.push_back(e);
      name_q.push_back(name);
   endtask

   task automatic idle_cycles(input int n, input string name);
      exp_t quiet;
      quiet = '0;
      repeat (n) begin
         @(posedge clk);
         in_valid <= 1'b0;
         exp_q.push_back(quiet);
         name_q.push_back(name);
      end
   endtask

   task automatic write_then_read(input string name, input logic [7:0] opcode, input int idx);
      send_request(name, opcode, idx, DW'($random(seed)));
      idle_cycles(2, name);
      send_request(name, umi_pkg::OP_READ, idx, '0);
   endtask

   // preset, atomic, later read back
   task automatic atomic_round(input string name, input logic [2:0] op, input int idx,
                               input logic [DW-1:0] old, input logic [DW-1:0] operand);
      send_request(name, umi_pkg::OP_WRITE_NORMAL, idx, old);
      idle_cycles(1, name);
      send_request(name, atomic_opcode(op), idx, operand);
      idle_cycles(1, name);
      send_request(name, umi_pkg::OP_READ, idx, '0);
   endtask

   initial begin
      seed       = 24;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_cmd     = '0;
      in_dstaddr = '0;
      in_srcaddr = '0;
      in_data    = '0;
      exp_cur    = '0;
      cur_name   = "reset";
      repeat (5) @(posedge clk);
      rst_n <= 1'b1;
      // two pipeline stages plus the sampling edge
      repeat (3) begin
         exp_q.push_back('0);
         name_q.push_back("pipeline fill");
      end
      idle_cycles(6, "quiet after reset");
      for (i = 0; i < WINDOW; i++) begin
         send_request("memory fill", umi_pkg::OP_WRITE_NORMAL, i, DW'($random(seed)));
      end
      write_then_read("normal write", umi_pkg::OP_WRITE_NORMAL, 1);
      write_then_read("signal write", umi_pkg::OP_WRITE_SIGNAL, 2);
      write_then_read("stream write", umi_pkg::OP_WRITE_STREAM, 3);
      // acked write followed by a stray response that must not land
      send_request("write ack", umi_pkg::OP_WRITE_ACK, 3, DW'($random(seed)));
      idle_cycles(2, "write ack");
      send_request("incoming response", umi_pkg::OP_WRITE_RESPONSE, 3, 32'hdead_beef);
      send_request("incoming response", umi_pkg::OP_READ, 3, '0);
      idle_cycles(2, "write ack");
      for (i = 0; i < 7; i++) begin
         rnd_old  = DW'($random(seed)) & 32'h7fff_ffff;
         rnd_opnd = DW'($random(seed));
         if (i >= 5) begin
            rnd_opnd = rnd_opnd | 32'h8000_0000; // negative against positive old
         end
         atomic_round("atomic ops", 3'(i), 4, rnd_old, rnd_opnd);
      end
      // operand wins max and loses min here
      atomic_round("signed max", umi_pkg::ATOMIC_MAX, 5, -32'sd9, -32'sd3);
      atomic_round("signed min", umi_pkg::ATOMIC_MIN, 5, -32'sd9, -32'sd3);
      // back to back on one word through the forwarding path
      send_request("write then read", umi_pkg::OP_WRITE_NORMAL, 6, DW'($random(seed)));
      send_request("write then read", umi_pkg::OP_READ, 6, '0);
      send_request("atomic chain", atomic_opcode(umi_pkg::ATOMIC_ADD), 7, 32'h11);
      send_request("atomic chain", atomic_opcode(umi_pkg::ATOMIC_ADD), 7, 32'h22);
      send_request("atomic chain", atomic_opcode(umi_pkg::ATOMIC_XOR), 7, 32'h0ff0);
      send_request("atomic chain", umi_pkg::OP_READ, 7, '0);
      idle_cycles(2, "atomic chain");
      // bad requests leave memory as it was
      send_request("opcode zero", umi_pkg::OP_INVALID, 0, 32'h1234_5678);
      send_request("opcode zero", umi_pkg::OP_READ, 0, '0);
      send_request("write kind 6", 8'h06, 0, 32'h2345_6789);
      send_request("write kind 6", umi_pkg::OP_READ, 0, '0);
      send_request("write kind 7", 8'h07, 0, 32'h3456_789a);
      send_request("write kind 7", umi_pkg::OP_READ, 0, '0);
      send_request("atomic op 7", atomic_opcode(3'd7), 0, 32'h4567_89ab);
      send_request("atomic op 7", umi_pkg::OP_READ, 0, '0);
      // random mix inside the window
      for (i = 0; i < RAND_REQS; i++) begin
         pick = $unsigned($random(seed)) % 8;
         case (pick)
            0, 1:    rnd_opcode = umi_pkg::OP_READ;
            2:       rnd_opcode = umi_pkg::OP_WRITE_NORMAL;
            3:       rnd_opcode = umi_pkg::OP_WRITE_ACK;
            4:       rnd_opcode = umi_pkg::OP_WRITE_STREAM;
            default: rnd_opcode = atomic_opcode(3'($unsigned($random(seed)) % 7));
         endcase
         if (pick == 7) begin
            idle_cycles(1, "random mix");
         end else begin
            send_request("random mix", rnd_opcode, $unsigned($random(seed)) % WINDOW,
                         DW'($random(seed)));
         end
      end
      idle_cycles(5, "drain");
      $display("all tests passed");
      $finish;
   end

endmodule

//--- tb.f
umi_pkg.sv
umi_decode.sv
umi_atomic_alu.sv
umi_mem_array.sv
umi_mem_endpoint.sv
umi_endpoint_top.sv
tb_umi_endpoint.sv
